// ==== common/kd_tree_params.svh ====
//================================================
// Tree geometry, component width and queue depths
//================================================
`ifndef KD_TREE_PARAMS_SVH
`define KD_TREE_PARAMS_SVH

// Tree shape
`define KD_TREE_DEPTH  6     // Levels, also the pipeline latency
`define KD_DIMS        5     // Components per patch
`define KD_COMP_WIDTH  11    // Bits per component
`define KD_NODE_COUNT  63    // 2**depth - 1 internal nodes

// Queue depths
`define KD_IN_DEPTH    4     // Also the sender's credits after reset
`define KD_OUT_DEPTH   4

`endif

// ==== common/kd_tree_pkg.sv ====
//================================================
// Vector types and packed structs for patches,
// node entries, config requests and leaf results
//================================================
`default_nettype none

`include "kd_tree_params.svh"

package kd_tree_pkg;

    typedef logic [`KD_COMP_WIDTH-1:0] comp_t;       // One patch component
    typedef logic [`KD_COMP_WIDTH-1:0] split_dim_t;  // Legal only below KD_DIMS
    typedef logic [`KD_TREE_DEPTH-1:0] node_addr_t;  // Heap order, root is 0
    typedef logic [`KD_TREE_DEPTH-1:0] leaf_idx_t;   // MSB is the root decision

    // Component 0 sits in the low bits
    typedef comp_t [`KD_DIMS-1:0] patch_t;

    typedef struct packed {
        split_dim_t split_dim;
        comp_t      median;
    } node_entry_t;

    typedef struct packed {
        logic        en;
        logic        we;    // 1 write, 0 read
        node_addr_t  addr;
        node_entry_t wdata;
    } cfg_req_t;

    // Query stays attached to its leaf for the stages after the tree
    typedef struct packed {
        leaf_idx_t leaf;
        patch_t    patch;
    } leaf_t;

endpackage

`default_nettype wire

// ==== kd_tree/kd_node_table.sv ====
//================================================
// Node register table with stream load, addressed
// bus access and a flat view for the tree stages
//================================================
`default_nettype none
`timescale 1ns/1ns

`include "kd_tree_params.svh"

module kd_node_table (
    input  logic                     clk,
    input  logic                     rst_n,
    input  kd_tree_pkg::cfg_req_t    cfg_req,
    output kd_tree_pkg::node_entry_t cfg_rdata,
    output logic                     cfg_rvalid,
    input  logic                     load_valid,
    input  kd_tree_pkg::node_entry_t load_data,
    output kd_tree_pkg::node_entry_t nodes [`KD_NODE_COUNT]
);
    import kd_tree_pkg::*;

    localparam node_addr_t LAST_NODE = node_addr_t'(`KD_NODE_COUNT - 1);

    node_addr_t  load_ptr;     // Next stream-load target
    logic        bus_wr;
    logic        bus_rd;
    logic        wr_en;
    node_addr_t  wr_addr;
    node_entry_t wr_data;

    assign bus_wr = cfg_req.en && cfg_req.we;
    assign bus_rd = cfg_req.en && !cfg_req.we;

    // Bus write beats the stream in the same cycle
    assign wr_addr = bus_wr ? cfg_req.addr  : load_ptr;
    assign wr_data = bus_wr ? cfg_req.wdata : load_data;
    assign wr_en   = (bus_wr || load_valid) && (wr_addr <= LAST_NODE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_ptr <= '0;
        end else if (load_valid && !bus_wr) begin
            load_ptr <= (load_ptr == LAST_NODE) ? '0 : load_ptr + 1'b1;  // Wrap after last node
        end
    end

    // Cleared nodes give a defined tree before the first load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int n = 0; n < `KD_NODE_COUNT; n++) begin
                nodes[n] <= '0;
            end
        end else if (wr_en) begin
            nodes[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= bus_rd;
        end
    end

    // Addresses past the last node read as zero
    always_ff @(posedge clk) begin
        if (bus_rd) begin
            cfg_rdata <= (cfg_req.addr <= LAST_NODE) ? nodes[cfg_req.addr] : '0;
        end
    end

    // Whatever the writer sends, a stored node names a real component
    a_split_dim_legal: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |=> (nodes[$past(wr_addr)].split_dim < `KD_DIMS));

endmodule

`default_nettype wire

// ==== kd_tree/kd_tree_stage.sv ====
//================================================
// One tree level: node pick, compare, path extend
//================================================
`default_nettype none
`timescale 1ns/1ns

`include "kd_tree_params.svh"

module kd_tree_stage #(
    parameter int LEVEL = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  kd_tree_pkg::patch_t      in_patch,
    input  kd_tree_pkg::leaf_idx_t   in_path,
    input  kd_tree_pkg::node_entry_t nodes [`KD_NODE_COUNT],
    output logic                     out_valid,
    output kd_tree_pkg::patch_t      out_patch,
    output kd_tree_pkg::leaf_idx_t   out_path
);
    import kd_tree_pkg::*;

    // First node of this level, also a mask for the path bits seen so far
    localparam int BASE = (1 << LEVEL) - 1;

    node_addr_t  node_sel;
    node_entry_t entry;
    comp_t       sel_comp;
    logic        go_right;

    assign node_sel = node_addr_t'(BASE) + (in_path & leaf_idx_t'(BASE));
    assign entry    = nodes[node_sel];

    // Component mux by split dimension
    always_comb begin
        sel_comp = '0;
        for (int d = 0; d < `KD_DIMS; d++) begin
            if (entry.split_dim == split_dim_t'(d)) begin
                sel_comp = in_patch[d];
            end
        end
    end

    assign go_right = (sel_comp > entry.median);  // Ties go left

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Decision shifts in at the bottom, root ends up as the MSB
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_patch <= in_patch;
            out_path  <= {in_path[`KD_TREE_DEPTH-2:0], go_right};
        end
    end

    a_node_dim_legal: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (entry.split_dim < `KD_DIMS));

endmodule

`default_nettype wire

// ==== kd_tree/kd_tree_pipeline.sv ====
//================================================
// Chain of tree stages, one per level
//================================================
`default_nettype none
`timescale 1ns/1ns

`include "kd_tree_params.svh"

module kd_tree_pipeline (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    input  kd_tree_pkg::patch_t      issue_patch,
    input  kd_tree_pkg::node_entry_t nodes [`KD_NODE_COUNT],
    output logic                     res_valid,
    output kd_tree_pkg::leaf_t       res
);
    import kd_tree_pkg::*;

    // Index k holds what enters level k, the last one is the result
    logic      stage_valid [`KD_TREE_DEPTH+1];
    patch_t    stage_patch [`KD_TREE_DEPTH+1];
    leaf_idx_t stage_path  [`KD_TREE_DEPTH+1];

    assign stage_valid[0] = issue_valid;
    assign stage_patch[0] = issue_patch;
    assign stage_path[0]  = '0;     // Empty path at the root

    for (genvar lvl = 0; lvl < `KD_TREE_DEPTH; lvl++) begin : g_level
        kd_tree_stage #(
            .LEVEL (lvl)
        ) u_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (stage_valid[lvl]),
            .in_patch  (stage_patch[lvl]),
            .in_path   (stage_path[lvl]),
            .nodes     (nodes),
            .out_valid (stage_valid[lvl+1]),
            .out_patch (stage_patch[lvl+1]),
            .out_path  (stage_path[lvl+1])
        );
    end

    assign res_valid = stage_valid[`KD_TREE_DEPTH];
    assign res       = '{leaf: stage_path[`KD_TREE_DEPTH], patch: stage_patch[`KD_TREE_DEPTH]};

endmodule

`default_nettype wire

// ==== logic/patch_ingress.sv ====
//================================================
// Credited input FIFO, issues when egress has room
//================================================
`default_nettype none
`timescale 1ns/1ns

`include "kd_tree_params.svh"

module patch_ingress (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                patch_valid,
    input  kd_tree_pkg::patch_t patch_in,
    output logic                patch_credit,
    input  logic                issue_ready,
    output logic                issue_valid,
    output kd_tree_pkg::patch_t issue_patch
);
    import kd_tree_pkg::*;

    localparam int PTR_W = $clog2(`KD_IN_DEPTH);
    localparam int CNT_W = $clog2(`KD_IN_DEPTH + 1);

    patch_t           fifo_mem [`KD_IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`KD_IN_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == CNT_W'(`KD_IN_DEPTH));
    assign push = patch_valid && !full;
    assign pop  = (count != '0) && issue_ready;

    assign issue_valid = pop;
    assign issue_patch = fifo_mem[rd_ptr];   // Head of queue

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            patch_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count        <= count + CNT_W'(push) - CNT_W'(pop);
            patch_credit <= pop;    // One credit back per issued patch
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= patch_in;
        end
    end

    // Sender overran its credits
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        patch_valid |-> !full);

endmodule

`default_nettype wire

// ==== logic/leaf_egress.sv ====
//================================================
// Output queue with in-flight reservation and
// a downstream credit counter
//================================================
`default_nettype none
`timescale 1ns/1ns

`include "kd_tree_params.svh"

module leaf_egress (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  logic               res_valid,
    input  kd_tree_pkg::leaf_t res,
    input  logic               leaf_credit,
    output logic               leaf_valid,
    output kd_tree_pkg::leaf_t leaf_out
);
    import kd_tree_pkg::*;

    localparam int PTR_W    = $clog2(`KD_OUT_DEPTH);
    localparam int CNT_W    = $clog2(`KD_OUT_DEPTH + 1);
    localparam int CREDIT_W = 8;

    leaf_t               q_mem [`KD_OUT_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    q_count;
    logic [CNT_W-1:0]    resv_count;   // In flight plus queued
    logic [CREDIT_W-1:0] credits;
    logic                pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`KD_OUT_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // A slot is held from issue until the leaf leaves
    assign issue_ready = (resv_count < CNT_W'(`KD_OUT_DEPTH));

    assign pop        = (q_count != '0) && (credits != '0);
    assign leaf_valid = pop;
    assign leaf_out   = q_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_count    <= '0;
            resv_count <= '0;
            credits    <= '0;
        end else begin
            if (res_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            q_count    <= q_count + CNT_W'(res_valid) - CNT_W'(pop);
            resv_count <= resv_count + CNT_W'(issue_valid) - CNT_W'(pop);

            // Grant and spend in the same cycle cancel out
            case ({leaf_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            q_mem[wr_ptr] <= res;
        end
    end

    // Reservation at issue must cover every result the pipeline returns
    a_no_queue_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (q_count < CNT_W'(`KD_OUT_DEPTH)));

endmodule

`default_nettype wire

// ==== logic/kd_tree_top.sv ====
//================================================
// KD-tree search top: ingress, tree pipeline,
// node table and egress
//================================================
`default_nettype none
`timescale 1ns/1ns

`include "kd_tree_params.svh"

module kd_tree_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     patch_valid,
    input  kd_tree_pkg::patch_t      patch_in,
    output logic                     patch_credit,
    input  logic                     leaf_credit,
    output logic                     leaf_valid,
    output kd_tree_pkg::leaf_t       leaf_out,
    input  kd_tree_pkg::cfg_req_t    cfg_req,
    output kd_tree_pkg::node_entry_t cfg_rdata,
    output logic                     cfg_rvalid,
    input  logic                     load_valid,
    input  kd_tree_pkg::node_entry_t load_data
);
    import kd_tree_pkg::*;

    logic        issue_valid;
    logic        issue_ready;
    patch_t      issue_patch;
    logic        res_valid;
    leaf_t       res;
    node_entry_t nodes [`KD_NODE_COUNT];    // Whole tree, seen by every stage

    patch_ingress u_ingress (
        .clk          (clk),
        .rst_n        (rst_n),
        .patch_valid  (patch_valid),
        .patch_in     (patch_in),
        .patch_credit (patch_credit),
        .issue_ready  (issue_ready),
        .issue_valid  (issue_valid),
        .issue_patch  (issue_patch)
    );

    kd_tree_pipeline u_pipeline (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_patch (issue_patch),
        .nodes       (nodes),
        .res_valid   (res_valid),
        .res         (res)
    );

    kd_node_table u_node_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_req    (cfg_req),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid),
        .load_valid (load_valid),
        .load_data  (load_data),
        .nodes      (nodes)
    );

    leaf_egress u_egress (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .res_valid   (res_valid),
        .res         (res),
        .leaf_credit (leaf_credit),
        .leaf_valid  (leaf_valid),
        .leaf_out    (leaf_out)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_kd_tree.sv ====
//================================================
// KD-tree search testbench with reference tree
// model, scoreboard, credit tracking and tests
//================================================
`default_nettype none
`timescale 1ns/1ns

`include "kd_tree_params.svh"

module tb_kd_tree;
    import kd_tree_pkg::*;

    localparam int PATCH_TOTAL     = 1 + 40 + 12;   // Patches over all tests
    localparam int WATCHDOG_CYCLES = PATCH_TOTAL * 20 + 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        patch_valid;
    patch_t      patch_in;
    logic        patch_credit;
    logic        leaf_credit;
    logic        leaf_valid;
    leaf_t       leaf_out;
    cfg_req_t    cfg_req;
    node_entry_t cfg_rdata;
    logic        cfg_rvalid;
    logic        load_valid;
    node_entry_t load_data;

    node_entry_t model_nodes [`KD_NODE_COUNT];  // Copy of the tree
    patch_t      pending_q [$];                 // Patches not yet sent
    leaf_t       expect_q [$];                  // Scoreboard in issue order
    int          sender_credits = `KD_IN_DEPTH;
    int          leaves_seen = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test = "reset";

    always #5 clk = ~clk;

    kd_tree_top u_kd_tree_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .patch_valid  (patch_valid),
        .patch_in     (patch_in),
        .patch_credit (patch_credit),
        .leaf_credit  (leaf_credit),
        .leaf_valid   (leaf_valid),
        .leaf_out     (leaf_out),
        .cfg_req      (cfg_req),
        .cfg_rdata    (cfg_rdata),
        .cfg_rvalid   (cfg_rvalid),
        .load_valid   (load_valid),
        .load_data    (load_data)
    );

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("ERROR: watchdog expired in test %s, the DUT stopped responding", cur_test);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Heap walk that goes right on greater and steps to child 2k+1 or 2k+2
    function automatic leaf_idx_t model_leaf(input patch_t p);
        int          node;
        leaf_idx_t   path;
        node_entry_t e;
        logic        right;
        node = 0;
        path = '0;
        for (int lvl = 0; lvl < `KD_TREE_DEPTH; lvl++) begin
            e     = model_nodes[node];
            right = (p[e.split_dim] > e.median);
            path  = {path[`KD_TREE_DEPTH-2:0], right};
            node  = 2 * node + 1 + int'(right);
        end
        return path;
    endfunction

    function automatic node_entry_t random_node();
        node_entry_t e;
        e.split_dim = split_dim_t'($urandom % `KD_DIMS);
        e.median    = comp_t'($urandom);
        return e;
    endfunction

    function automatic patch_t random_patch();
        patch_t p;
        for (int d = 0; d < `KD_DIMS; d++) begin
            p[d] = comp_t'($urandom);
        end
        return p;
    endfunction

    task automatic check_leaf(input leaf_t exp, input leaf_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected leaf %0d patch %h, actual leaf %0d patch %h",
                     cur_test, exp.leaf, exp.patch, act.leaf, act.patch);
        end
    endtask

    task automatic check_node(input node_entry_t exp, input node_entry_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected dim %0d median %0d, actual dim %0d median %0d",
                     cur_test, exp.split_dim, exp.median, act.split_dim, act.median);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR %s: %s", cur_test, what);
    endtask

    // Monitor at the falling edge, between register updates
    always @(negedge clk) begin
        if (rst_n) begin
            if (patch_credit) sender_credits++;
            if (leaf_valid) begin
                leaves_seen++;
                if (expect_q.size() == 0) report_error("leaf_valid with no result outstanding");
                else check_leaf(expect_q.pop_front(), leaf_out);
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_node(input int a, input node_entry_t e);
        cfg_req_t r;
        r       = '0;
        r.en    = 1'b1;
        r.we    = 1'b1;
        r.addr  = node_addr_t'(a);
        r.wdata = e;
        cfg_req = r;
        step();
        cfg_req = '0;
        if (a < `KD_NODE_COUNT) model_nodes[a] = e;
    endtask

    task automatic read_node(input int a, output node_entry_t d);
        cfg_req_t r;
        int       waited;
        r       = '0;
        r.en    = 1'b1;
        r.addr  = node_addr_t'(a);
        cfg_req = r;
        step();
        cfg_req = '0;
        waited  = 0;
        while (!cfg_rvalid && waited < 4) begin
            step();
            waited++;
        end
        d = cfg_rdata;
        if (!cfg_rvalid) begin
            report_error($sformatf("no read response for node %0d", a));
            d = '0;
        end
    endtask

    // Sends the next patch in one cycle of traffic if a credit is held
    task automatic offer_cycle(input logic give_credit);
        patch_t p;
        leaf_t  exp;
        if (pending_q.size() != 0 && sender_credits > 0) begin
            p           = pending_q.pop_front();
            patch_valid = 1'b1;
            patch_in    = p;
            sender_credits--;
            exp.leaf    = model_leaf(p);
            exp.patch   = p;
            expect_q.push_back(exp);
        end else begin
            patch_valid = 1'b0;
        end
        leaf_credit = give_credit;
        step();
    endtask

    task automatic run_traffic(input int grants, input int spacing, input int max_cycles);
        int granted;
        int cyc;
        granted = 0;
        cyc     = 0;
        while (cyc < max_cycles && (pending_q.size() != 0 || expect_q.size() != 0)) begin
            offer_cycle(granted < grants && (cyc % spacing) == 0);
            if (leaf_credit) granted++;
            cyc++;
        end
        patch_valid = 1'b0;
        leaf_credit = 1'b0;
        if (pending_q.size() != 0 || expect_q.size() != 0)
            report_error($sformatf("timed out with %0d patches unsent and %0d leaves missing",
                                   pending_q.size(), expect_q.size()));
    endtask

    task automatic start_test(input string name, output int errs_before);
        cur_test    = name;
        errs_before = errors;
        tests_run++;
    endtask

    task automatic end_test(input int errs_before);
        if (errors != errs_before) tests_failed++;
        $display("[%s] %s", cur_test, (errors == errs_before) ? "ok" : "errors found");
    endtask

    task automatic load_and_readback();
        int          eb;
        node_entry_t d;
        start_test("stream_load", eb);
        for (int i = 0; i < `KD_NODE_COUNT; i++) begin
            model_nodes[i] = random_node();
            load_valid     = 1'b1;
            load_data      = model_nodes[i];
            step();
        end
        load_valid = 1'b0;
        for (int i = 0; i < `KD_NODE_COUNT; i++) begin
            read_node(i, d);
            check_node(model_nodes[i], d);
        end
        read_node(`KD_NODE_COUNT, d);   // Past the last node
        check_node('0, d);
        end_test(eb);
    endtask

    task automatic override_root();
        int          eb;
        node_entry_t e;
        node_entry_t d;
        start_test("bus_override", eb);
        e.split_dim = split_dim_t'(2);
        e.median    = comp_t'($urandom);
        write_node(0, e);               // Root decides every path
        read_node(0, d);
        check_node(e, d);
        pending_q.push_back(random_patch());
        run_traffic(1, 1, 100);
        end_test(eb);
    endtask

    task automatic burst_of_patches();
        int eb;
        start_test("burst", eb);
        repeat (40) pending_q.push_back(random_patch());
        run_traffic(40, 1, 40 * 20);
        end_test(eb);
    endtask

    task automatic backpressure_stall();
        int eb;
        int seen_before;
        int accepted;
        start_test("backpressure", eb);
        repeat (12) pending_q.push_back(random_patch());
        seen_before = leaves_seen;
        repeat (40) offer_cycle(1'b0);  // No output credits at all
        patch_valid = 1'b0;
        accepted    = 12 - pending_q.size();
        if (leaves_seen != seen_before) report_error("leaf sent without an output credit");
        if (accepted != `KD_IN_DEPTH + `KD_OUT_DEPTH)
            report_error($sformatf("%0d patches accepted while stalled, expected %0d",
                                   accepted, `KD_IN_DEPTH + `KD_OUT_DEPTH));
        if (sender_credits != 0)
            report_error($sformatf("sender still holds %0d credits while stalled",
                                   sender_credits));
        run_traffic(12, 3, 12 * 20);    // Spaced single credits
        if (leaves_seen - seen_before != 12)
            report_error($sformatf("%0d leaves received, expected 12",
                                   leaves_seen - seen_before));
        end_test(eb);
    endtask

    task automatic drain_credits();
        int eb;
        int seen_before;
        start_test("credit_return", eb);
        repeat (20) step();
        seen_before = leaves_seen;
        repeat (3) offer_cycle(1'b1);   // Spare credits must not pull out a leaf
        leaf_credit = 1'b0;
        repeat (20) step();
        if (sender_credits != `KD_IN_DEPTH)
            report_error($sformatf("sender holds %0d credits after drain, expected %0d",
                                   sender_credits, `KD_IN_DEPTH));
        if (leaves_seen != seen_before) report_error("extra leaf_valid after drain");
        end_test(eb);
    endtask

    initial begin
        void'($urandom(32'hc587));
        rst_n       = 1'b0;
        patch_valid = 1'b0;
        patch_in    = '0;
        leaf_credit = 1'b0;
        cfg_req     = '0;
        load_valid  = 1'b0;
        load_data   = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        load_and_readback();
        override_root();
        burst_of_patches();
        backpressure_stall();
        drain_credits();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/kd_tree_pkg.sv
kd_tree/kd_node_table.sv
kd_tree/kd_tree_stage.sv
kd_tree/kd_tree_pipeline.sv
logic/patch_ingress.sv
logic/leaf_egress.sv
logic/kd_tree_top.sv
testbench/tb_kd_tree.sv
